//--- all.f
src/streamPkg.sv
src/configRegs.sv
src/ingressMeter.sv
src/pipeStage.sv
src/outputPadder.sv
src/streamTop.sv
verif/streamTb.sv

//--- src/configRegs.sv
// register slave with single-cycle ack; job registers are frozen while busy, addresses 5..7 read 0
`timescale 1ns/1ps

module configRegs (
    input  logic                CLK,
    input  logic                ARESETN,
    input  streamPkg::wbReq_t   wbReq,
    input  logic                ingressDone,
    input  logic                egressDone,
    output streamPkg::wbRsp_t   wbRsp,
    output logic                jobStart,
    output streamPkg::jobCfg_t  jobCfg,
    output logic                irq,
    output logic [7:0]          led
);

    streamPkg::regWord_t cmdReg;
    streamPkg::regWord_t srcReg;
    streamPkg::regWord_t destReg;
    streamPkg::regWord_t lenReg;
    streamPkg::regWord_t rdMux;
    logic                busy;
    logic                reqTake;
    logic                wrTake;
    logic                startTake;
    logic                jobEnd;
    logic [35:0]         scaledLen;

    // ----------------------------------------------------------
    // bus decode
    // ----------------------------------------------------------
    assign reqTake   = wbReq.cyc && wbReq.stb && !wbRsp.ack;           // new access this cycle
    assign wrTake    = reqTake && wbReq.we;
    assign startTake = wrTake && (wbReq.adr == streamPkg::REG_CMD) && !busy;
    // done levels from the last job are stale until the blocks see the pulse
    assign jobEnd    = busy && !jobStart && ingressDone && egressDone;

    // output bytes = input bytes * 256 >> scale
    assign scaledLen = {lenReg[27:0], 8'd0} >> lenReg[31:streamPkg::LEN_SCALE_LSB];

    always_comb begin
        case (wbReq.adr)
            streamPkg::REG_CMD:    rdMux = cmdReg;
            streamPkg::REG_SRC:    rdMux = srcReg;
            streamPkg::REG_DEST:   rdMux = destReg;
            streamPkg::REG_LEN:    rdMux = lenReg;
            streamPkg::REG_STATUS: begin
                rdMux = '0;
                rdMux[streamPkg::STAT_BUSY_BIT] = busy;
                rdMux[streamPkg::STAT_IRQ_BIT]  = irq;
            end
            default:               rdMux = '0;                         // unmapped
        endcase
    end

    // ----------------------------------------------------------
    // registers and job control
    // ----------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            wbRsp.ack <= 1'b0;
            jobStart  <= 1'b0;
            busy      <= 1'b0;
            irq       <= 1'b0;
            led       <= 8'd0;
            cmdReg    <= '0;
            srcReg    <= '0;
            destReg   <= '0;
            lenReg    <= '0;
        end else begin
            wbRsp.ack <= reqTake;                                      // ack one edge later
            jobStart  <= startTake;
            if (reqTake) begin
                wbRsp.dat <= rdMux;                                    // held with ack
            end
            if (wrTake && !busy) begin
                case (wbReq.adr)
                    streamPkg::REG_CMD:  cmdReg  <= wbReq.dat;
                    streamPkg::REG_SRC:  srcReg  <= wbReq.dat;
                    streamPkg::REG_DEST: destReg <= wbReq.dat;
                    streamPkg::REG_LEN:  lenReg  <= wbReq.dat;
                    default: ;                                         // status handled below
                endcase
            end
            if (startTake) begin
                busy            <= 1'b1;
                led             <= {wbReq.dat[1:0], srcReg[2:0], destReg[2:0]};
                jobCfg.inBytes  <= {4'd0, lenReg[27:0]};
                jobCfg.outBytes <= scaledLen[31:0];                    // top bits dropped
            end else if (jobEnd) begin
                busy <= 1'b0;
            end
            if (jobEnd) begin
                irq <= 1'b1;                                           // set wins over clear
            end else if (wrTake && (wbReq.adr == streamPkg::REG_STATUS)
                         && wbReq.dat[streamPkg::STAT_IRQ_BIT]) begin
                irq <= 1'b0;
            end
        end
    end

    // classic handshake, ack must drop between accesses
    ackSingle: assert property (@(posedge CLK) disable iff (!ARESETN)
        wbRsp.ack |=> !wbRsp.ack);

endmodule

//--- src/ingressMeter.sv
// input gate for the active job; counts whole words, so a partial last word still takes 8 bytes
`timescale 1ns/1ps

module ingressMeter (
    input  logic                    CLK,
    input  logic                    ARESETN,
    input  logic                    jobStart,
    input  streamPkg::jobCfg_t      jobCfg,
    input  streamPkg::dataWord_t    inData,
    input  logic                    inValid,
    input  logic                    stageReady,
    output logic                    inReady,
    output streamPkg::streamBeat_t  stageIn,
    output logic                    ingressDone
);

    logic        armed;                             // a job has been started
    logic [31:0] inCount;                           // bytes admitted so far
    logic        admit;

    // ----------------------------------------------------------
    // admission
    // ----------------------------------------------------------
    assign admit       = armed && !jobStart && (inCount < jobCfg.inBytes);  // room left, not restarting
    assign inReady     = admit && stageReady;                    // first stage must have space
    assign stageIn.valid = inValid && admit;
    assign stageIn.data  = inData;                               // no register on this path
    assign ingressDone = armed && !admit;                        // held until the next start

    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            armed   <= 1'b0;
            inCount <= '0;
        end else if (jobStart) begin
            armed   <= 1'b1;                        // first word one cycle after this edge
            inCount <= '0;
        end else if (inValid && inReady) begin
            inCount <= inCount + 32'(streamPkg::BEAT_BYTES);
        end
    end

endmodule

//--- src/outputPadder.sv
// output byte enforcer; the wait timer runs from job start, so late words after fill begins are lost
`timescale 1ns/1ps

module outputPadder #(
    parameter int WAIT_CYCLES = 2048                // cycles before filler starts
) (
    input  logic                    CLK,
    input  logic                    ARESETN,
    input  logic                    jobStart,
    input  streamPkg::jobCfg_t      jobCfg,
    input  streamPkg::streamBeat_t  pipeBeat,
    input  logic                    outReady,
    output logic                    pipeReady,
    output streamPkg::dataWord_t    outData,
    output logic                    outValid,
    output logic                    egressDone
);

    streamPkg::streamBeat_t outQ;                   // output register
    logic        running;                           // armed by the first job
    logic        fillMode;
    logic [31:0] sent;                              // bytes handed over on the output
    logic [31:0] issued;                            // sent plus the word in outQ
    logic [31:0] waitCnt;                           // cycles since job start
    logic        slotFree;
    logic        want;
    logic        loadPipe;
    logic        loadFill;

    // ----------------------------------------------------------
    // flow decisions
    // ----------------------------------------------------------
    assign issued   = sent + (outQ.valid ? 32'(streamPkg::BEAT_BYTES) : 32'd0);
    assign slotFree = !outQ.valid || outReady;      // outQ can take a word this edge
    assign want     = running && (issued < jobCfg.outBytes);
    assign loadPipe = !fillMode && want && slotFree && pipeBeat.valid;
    assign loadFill = fillMode && want && slotFree;
    // surplus and fill-time words are swallowed
    assign pipeReady = fillMode || !want || slotFree;

    assign outValid   = outQ.valid;
    assign outData    = outQ.data;
    assign egressDone = running && (sent >= jobCfg.outBytes);

    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            running    <= 1'b0;
            fillMode   <= 1'b0;
            sent       <= '0;
            waitCnt    <= '0;
            outQ.valid <= 1'b0;
        end else if (jobStart) begin
            running    <= 1'b1;                     // outQ already empty when idle
            fillMode   <= 1'b0;
            sent       <= '0;
            waitCnt    <= '0;
            outQ.valid <= 1'b0;
        end else begin
            if (running && !fillMode) begin
                waitCnt <= waitCnt + 32'd1;         // stops once filling
            end
            if (waitCnt > 32'(WAIT_CYCLES)) begin
                fillMode <= 1'b1;
            end
            if (outQ.valid && outReady) begin
                sent <= sent + 32'(streamPkg::BEAT_BYTES);
            end
            if (loadPipe) begin
                outQ <= pipeBeat;                   // valid set by the load
            end else if (loadFill) begin
                outQ.valid <= 1'b1;
                outQ.data  <= streamPkg::FILL_WORD;
            end else if (outReady) begin
                outQ.valid <= 1'b0;                 // drained, nothing new
            end
        end
    end

    // load gating on issued keeps the output inside the byte budget
    noOverrun: assert property (@(posedge CLK) disable iff (!ARESETN)
        outQ.valid |-> sent < jobCfg.outBytes);

endmodule

//--- src/pipeStage.sv
// two-entry skid stage; ready comes from a flop, so a chain of stages has no combinational ready path
`timescale 1ns/1ps

module pipeStage (
    input  logic                    CLK,
    input  logic                    ARESETN,
    input  streamPkg::streamBeat_t  upBeat,
    input  logic                    downReady,
    output logic                    upReady,
    output streamPkg::streamBeat_t  downBeat
);

    streamPkg::streamBeat_t mainQ;                  // drives the output
    streamPkg::streamBeat_t skidQ;                  // catches the word in flight on a stall
    logic                   mainFree;

    assign mainFree = !mainQ.valid || downReady;    // main empties or moves on this edge
    assign upReady  = !skidQ.valid;                 // registered, high while skid is empty
    assign downBeat = mainQ;

    // ----------------------------------------------------------
    // main and skid update
    // ----------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            mainQ.valid <= 1'b0;
            skidQ.valid <= 1'b0;
        end else if (mainFree) begin
            if (skidQ.valid) begin
                mainQ       <= skidQ;               // older word first
                skidQ.valid <= 1'b0;
            end else begin
                mainQ <= upBeat;                    // upReady is high here
            end
        end else if (upBeat.valid && upReady) begin
            skidQ <= upBeat;                        // main stalled, park it
        end
    end

    // stalled word must not change under the consumer
    holdStable: assert property (@(posedge CLK) disable iff (!ARESETN)
        downBeat.valid && !downReady |=> downBeat.valid && $stable(downBeat.data));

endmodule

//--- src/streamPkg.sv
// shared types for the stream engine; byte counts assume whole 8-byte words, 3-bit register space
package streamPkg;

    // ----------------------------------------------------------
    // stream payload
    // ----------------------------------------------------------
    localparam int unsigned BEAT_BYTES = 8;         // bytes moved per word
    typedef logic [63:0] dataWord_t;                // one stream word
    localparam dataWord_t FILL_WORD = 64'hDEAD;     // pad value for underflow

    typedef struct packed {
        logic      valid;                           // word present
        dataWord_t data;
    } streamBeat_t;                                 // 65 bits, ready travels beside it

    // ----------------------------------------------------------
    // register map
    // ----------------------------------------------------------
    typedef logic [31:0] regWord_t;

    typedef enum logic [2:0] {
        REG_CMD    = 3'd0,                          // write while idle starts a job
        REG_SRC    = 3'd1,                          // source tag
        REG_DEST   = 3'd2,                          // destination tag
        REG_LEN    = 3'd3,                          // scale and input bytes
        REG_STATUS = 3'd4                           // busy and irq
    } regAddr_t;

    localparam int LEN_SCALE_LSB = 28;              // scale nibble sits in 31..28
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_IRQ_BIT  = 1;               // write 1 to clear

    // ----------------------------------------------------------
    // bus and job bundles
    // ----------------------------------------------------------
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        regAddr_t adr;                              // word address
        regWord_t dat;                              // write data
    } wbReq_t;

    typedef struct packed {
        logic     ack;                              // one cycle per access
        regWord_t dat;                              // read data, valid with ack
    } wbRsp_t;

    typedef struct packed {
        logic [31:0] inBytes;                       // bytes taken from the input
        logic [31:0] outBytes;                      // bytes sent on the output
    } jobCfg_t;

endpackage

//--- src/streamTop.sv
// stream engine top; one job at a time, surplus words left in the stages drain before the next start
`timescale 1ns/1ps

module streamTop #(
    parameter int NUM_STAGES  = 3,                  // 1 or more
    parameter int WAIT_CYCLES = 2048
) (
    input  logic                  CLK,
    input  logic                  ARESETN,
    input  streamPkg::wbReq_t     wbReq,
    input  streamPkg::dataWord_t  inData,
    input  logic                  inValid,
    input  logic                  outReady,
    output streamPkg::wbRsp_t     wbRsp,
    output logic                  inReady,
    output streamPkg::dataWord_t  outData,
    output logic                  outValid,
    output logic                  irq,
    output logic [7:0]            led
);

    logic                   jobStart;
    streamPkg::jobCfg_t     jobCfg;
    logic                   ingressDone;
    logic                   egressDone;
    streamPkg::streamBeat_t stageBeat [NUM_STAGES+1];   // [0] from meter, last to padder
    logic                   stageReady [NUM_STAGES+1];

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    configRegs u_cfg (
        .CLK         (CLK),
        .ARESETN     (ARESETN),
        .wbReq       (wbReq),
        .ingressDone (ingressDone),
        .egressDone  (egressDone),
        .wbRsp       (wbRsp),
        .jobStart    (jobStart),
        .jobCfg      (jobCfg),
        .irq         (irq),
        .led         (led)
    );

    ingressMeter u_meter (
        .CLK         (CLK),
        .ARESETN     (ARESETN),
        .jobStart    (jobStart),
        .jobCfg      (jobCfg),
        .inData      (inData),
        .inValid     (inValid),
        .stageReady  (stageReady[0]),
        .inReady     (inReady),
        .stageIn     (stageBeat[0]),
        .ingressDone (ingressDone)
    );

    // ----------------------------------------------------------
    // pipeline chain
    // ----------------------------------------------------------
    for (genvar k = 0; k < NUM_STAGES; k++) begin : gStage
        pipeStage u_stage (
            .CLK       (CLK),
            .ARESETN   (ARESETN),
            .upBeat    (stageBeat[k]),
            .downReady (stageReady[k+1]),
            .upReady   (stageReady[k]),
            .downBeat  (stageBeat[k+1])
        );
    end

    outputPadder #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_padder (
        .CLK        (CLK),
        .ARESETN    (ARESETN),
        .jobStart   (jobStart),
        .jobCfg     (jobCfg),
        .pipeBeat   (stageBeat[NUM_STAGES]),
        .outReady   (outReady),
        .pipeReady  (stageReady[NUM_STAGES]),
        .outData    (outData),
        .outValid   (outValid),
        .egressDone (egressDone)
    );

endmodule

//--- verif/streamTb.sv
// directed testbench for 3 stages and a 64-cycle wait; stops at the first mismatch, no waves
`timescale 1ns/1ps

module streamTb;

    localparam int NUM_STAGES  = 3;
    localparam int WAIT_CYCLES = 64;
    // 3 jobs of at most 16 words, each under ~150 cycles with bus traffic and the fill wait
    localparam int MAX_CYCLES  = 3000;

    logic                  CLK = 1'b0;
    logic                  ARESETN;
    streamPkg::wbReq_t     wbReq;
    streamPkg::wbRsp_t     wbRsp;
    streamPkg::dataWord_t  inData;
    logic                  inValid;
    logic                  inReady;
    logic                  outReady;
    streamPkg::dataWord_t  outData;
    logic                  outValid;
    logic                  irq;
    logic [7:0]            led;

    streamPkg::dataWord_t  inWords [$];             // stimulus of the current job
    streamPkg::dataWord_t  outWords [$];            // words taken from the output
    int                    cycleCount = 0;

    always #20 CLK = ~CLK;                          // 40 ns period

    streamTop #(
        .NUM_STAGES  (NUM_STAGES),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_dut (
        .CLK      (CLK),
        .ARESETN  (ARESETN),
        .wbReq    (wbReq),
        .inData   (inData),
        .inValid  (inValid),
        .outReady (outReady),
        .wbRsp    (wbRsp),
        .inReady  (inReady),
        .outData  (outData),
        .outValid (outValid),
        .irq      (irq),
        .led      (led)
    );

    // ----------------------------------------------------------
    // watchdog and compare
    // ----------------------------------------------------------
    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic checkEq(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ----------------------------------------------------------
    // Wishbone host
    // ----------------------------------------------------------
    task automatic wbWrite(input streamPkg::regAddr_t addr, input streamPkg::regWord_t data);
        @(posedge CLK);
        wbReq.cyc <= 1'b1;
        wbReq.stb <= 1'b1;
        wbReq.we  <= 1'b1;
        wbReq.adr <= addr;
        wbReq.dat <= data;
        @(negedge CLK);
        while (!wbRsp.ack) @(negedge CLK);           // write lands on the ack edge
        @(posedge CLK);
        wbReq.cyc <= 1'b0;                          // end of cycle
        wbReq.stb <= 1'b0;
        wbReq.we  <= 1'b0;
    endtask

    task automatic wbRead(input streamPkg::regAddr_t addr, output streamPkg::regWord_t data);
        @(posedge CLK);
        wbReq.cyc <= 1'b1;
        wbReq.stb <= 1'b1;
        wbReq.we  <= 1'b0;
        wbReq.adr <= addr;
        @(negedge CLK);
        while (!wbRsp.ack) @(negedge CLK);
        data = wbRsp.dat;                           // valid while ack is high
        @(posedge CLK);
        wbReq.cyc <= 1'b0;
        wbReq.stb <= 1'b0;
    endtask

    // ----------------------------------------------------------
    // job helpers
    // ----------------------------------------------------------
    task automatic startJob(input streamPkg::regWord_t cmd, input streamPkg::regWord_t src,
                            input streamPkg::regWord_t dest, input streamPkg::regWord_t len);
        streamPkg::regWord_t rd;
        wbWrite(streamPkg::REG_SRC, src);
        wbWrite(streamPkg::REG_DEST, dest);
        wbWrite(streamPkg::REG_LEN, len);
        wbRead(streamPkg::REG_SRC, rd);
        checkEq("SRC", src, rd);
        wbRead(streamPkg::REG_DEST, rd);
        checkEq("DEST", dest, rd);
        wbRead(streamPkg::REG_LEN, rd);
        checkEq("LEN", len, rd);
        wbWrite(streamPkg::REG_CMD, cmd);           // idle, so this starts the job
        @(negedge CLK);
        checkEq("led", {cmd[1:0], src[2:0], dest[2:0]}, led);   // cmd, src, dest bits
        wbRead(streamPkg::REG_STATUS, rd);
        checkEq("STATUS.busy", 1, rd[0]);
    endtask

    task automatic fillInputs(input int n);
        inWords.delete();
        outWords.delete();
        for (int i = 0; i < n; i++) begin
            inWords.push_back({$urandom, $urandom});
        end
    endtask

    task automatic sendWords(input int n);
        @(posedge CLK);
        for (int i = 0; i < n; i++) begin
            inValid <= 1'b1;
            inData  <= inWords[i];                  // held until taken
            @(negedge CLK);
            while (!inReady) @(negedge CLK);
            @(posedge CLK);                         // word moves here
        end
        inValid <= 1'b0;
    endtask

    task automatic collectWords(input int n, input bit randomReady);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge CLK);
            outReady <= randomReady ? ($urandom % 4 != 0) : 1'b1;   // ready 3 of 4 cycles
            @(negedge CLK);
            if (outValid && outReady) begin
                outWords.push_back(outData);        // taken at the next edge
                got++;
            end
        end
    endtask

    task automatic finishJob();
        streamPkg::regWord_t rd;
        @(negedge CLK);
        while (!irq) begin
            checkEq("extra output word", 0, outValid && outReady);
            @(negedge CLK);
        end
        wbRead(streamPkg::REG_STATUS, rd);
        checkEq("STATUS.busy", 0, rd[0]);
        checkEq("STATUS.irq", 1, rd[1]);
        wbWrite(streamPkg::REG_STATUS, 32'h2);      // clear irq
        @(negedge CLK);
        checkEq("irq", 0, irq);
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    task automatic testReset();
        @(negedge CLK);
        checkEq("outValid", 0, outValid);
        checkEq("inReady", 0, inReady);
        checkEq("wbRsp.ack", 0, wbRsp.ack);
        checkEq("irq", 0, irq);
        checkEq("led", 0, led);
    endtask

    task automatic testEqualLength();
        fillInputs(16);
        startJob(32'h1, 32'h5, 32'h3, {4'd8, 28'd128});     // 128 bytes in, 128 out
        fork
            sendWords(16);
            collectWords(16, 1'b1);
        join
        for (int i = 0; i < 16; i++) begin
            checkEq($sformatf("outData[%0d]", i), inWords[i], outWords[i]);
        end
        finishJob();
    endtask

    task automatic testSurplus();
        fillInputs(8);
        startJob(32'h2, 32'h6, 32'h1, {4'd9, 28'd64});      // 64 in, 32 out
        fork
            sendWords(8);
            collectWords(4, 1'b0);
        join
        for (int i = 0; i < 4; i++) begin
            checkEq($sformatf("outData[%0d]", i), inWords[i], outWords[i]);
        end
        @(negedge CLK);
        checkEq("inReady", 0, inReady);             // all 8 taken, gate closed
        finishJob();
    endtask

    task automatic testUnderflow();
        fillInputs(4);
        startJob(32'h3, 32'h7, 32'h4, {4'd7, 28'd32});      // 32 in, 64 out
        fork
            sendWords(4);
            collectWords(8, 1'b0);
        join
        for (int i = 0; i < 8; i++) begin
            checkEq($sformatf("outData[%0d]", i), (i < 4) ? inWords[i] : 64'hDEAD,
                    outWords[i]);
        end
        finishJob();
    endtask

    initial begin
        void'($urandom(11276));
        ARESETN  = 1'b0;
        wbReq    = '0;
        inData   = '0;
        inValid  = 1'b0;
        outReady = 1'b0;
        repeat (2) @(posedge CLK);
        ARESETN <= 1'b1;
        testReset();
        testEqualLength();
        testSurplus();
        testUnderflow();
        $display("TEST PASSED");
        $finish;
    end

endmodule
